/* include/game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Grid geometry.
`define GRID_N 4
`define TILE_W 4

// Exponent of the 2048 tile.
`define WIN_EXP 11

`define FIFO_DEPTH 4

// Galois LFSR for tile placement.
`define SPAWN_SEED 16'hACE1
`define SPAWN_TAPS 16'hB400

`endif

/* rtl/game_pkg.sv */
package game_pkg;

	// Move direction, also the order tried when looking for a legal move.
	typedef enum logic [1:0] {
		dir_left  = 2'd0,
		dir_right = 2'd1,
		dir_up    = 2'd2,
		dir_down  = 2'd3
	} dir_t;

	typedef enum logic [2:0] {
		st_idle   = 3'd0,
		st_start  = 3'd1,
		st_play   = 3'd2,
		st_slide  = 3'd3,
		st_spawn  = 3'd4,
		st_check  = 3'd5,
		st_win    = 3'd6,
		st_defeat = 3'd7
	} fsm_state_t;

endpackage

/* rtl/button_edge.sv */
`timescale 1ns/1ps

module button_edge (
	input  logic            clk,
	input  logic            reset,
	input  logic            btn_left,
	input  logic            btn_right,
	input  logic            btn_up,
	input  logic            btn_down,
	output logic            req_valid,
	output game_pkg::dir_t  req_dir,
	input  logic            req_ready
);
	import game_pkg::*;

	logic prev_left, prev_right, prev_up, prev_down;
	logic rel_left, rel_right, rel_up, rel_down;
	logic rel_any;
	dir_t sel_dir;

	// High last cycle, low now.
	assign rel_left  = prev_left & ~btn_left;
	assign rel_right = prev_right & ~btn_right;
	assign rel_up    = prev_up & ~btn_up;
	assign rel_down  = prev_down & ~btn_down;
	assign rel_any   = rel_left | rel_right | rel_up | rel_down;

	// Fixed priority.
	always_comb begin
		if (rel_right)
			sel_dir = dir_right;
		else if (rel_left)
			sel_dir = dir_left;
		else if (rel_up)
			sel_dir = dir_up;
		else
			sel_dir = dir_down;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prev_left  <= 1'b0;
			prev_right <= 1'b0;
			prev_up    <= 1'b0;
			prev_down  <= 1'b0;
			req_valid  <= 1'b0;
		end else begin
			prev_left  <= btn_left;
			prev_right <= btn_right;
			prev_up    <= btn_up;
			prev_down  <= btn_down;
			// A release while a request is pending is lost.
			if (req_valid) begin
				if (req_ready)
					req_valid <= 1'b0;
			end else if (rel_any) begin
				req_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!req_valid && rel_any)
			req_dir <= sel_dir;
	end

endmodule

/* rtl/move_fifo.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module move_fifo (
	input  logic            clk,
	input  logic            reset,
	input  logic            req_valid,
	input  game_pkg::dir_t  req_dir,
	output logic            req_ready,
	output logic            mv_valid,
	output game_pkg::dir_t  mv_dir,
	input  logic            mv_ready,
	output logic            empty
);
	import game_pkg::*;

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	dir_t             mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push, pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`FIFO_DEPTH - 1))
			return '0;
		return p + PTR_W'(1);
	endfunction

	assign req_ready = (count != CNT_W'(`FIFO_DEPTH));
	assign mv_valid  = (count != '0);
	assign empty     = (count == '0);
	assign mv_dir    = mem[rd_ptr];

	assign push = req_valid & req_ready;
	assign pop  = mv_valid & mv_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				count <= count + CNT_W'(1);
			else if (pop && !push)
				count <= count - CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= req_dir;
	end

	// An underflow would wrap count above the depth.
	a_count_range: assert property (@(posedge clk) disable iff (reset)
		count <= CNT_W'(`FIFO_DEPTH));

endmodule

/* rtl/tile_slide.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module tile_slide (
	input  logic [`GRID_N*`TILE_W-1:0] line_in,
	output logic [`GRID_N*`TILE_W-1:0] line_out
);

	localparam int N = `GRID_N;
	localparam int W = `TILE_W;

	// One spare zero cell past the tail keeps the pair compare in range.
	logic [W-1:0] comp [N+1];
	logic [W-1:0] res  [N];

	always_comb begin : slide
		int  n;
		int  k;
		logic skip;

		for (int i = 0; i <= N; i++)
			comp[i] = '0;
		for (int i = 0; i < N; i++)
			res[i] = '0;

		// Squeeze out the empty cells.
		n = 0;
		for (int i = 0; i < N; i++) begin
			if (line_in[i*W +: W] != '0) begin
				comp[n] = line_in[i*W +: W];
				n = n + 1;
			end
		end

		// Merge head pairs first, each tile at most once.
		k = 0;
		skip = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (skip) begin
				skip = 1'b0;
			end else if (comp[i] != '0 && comp[i] == comp[i+1]) begin
				res[k] = comp[i] + W'(1);
				k = k + 1;
				skip = 1'b1;
			end else begin
				res[k] = comp[i];
				k = k + 1;
			end
		end

		for (int i = 0; i < N; i++)
			line_out[i*W +: W] = res[i];
	end

endmodule

/* rtl/tile_spawner.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module tile_spawner (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                spawn,
	input  logic [`GRID_N*`GRID_N*`TILE_W-1:0]  grid,
	output logic [`GRID_N*`GRID_N*`TILE_W-1:0]  grid_spawned,
	output logic                                has_empty
);

	localparam int W     = `TILE_W;
	localparam int CELLS = `GRID_N * `GRID_N;
	localparam int IDX_W = $clog2(CELLS);

	logic [15:0]      lfsr;
	logic [IDX_W-1:0] start;
	logic [W-1:0]     new_val;
	logic [IDX_W-1:0] pos;
	logic             found;

	assign start   = lfsr[IDX_W-1:0];
	// A 4 one time in eight.
	assign new_val = (lfsr[7:5] == 3'b000) ? W'(2) : W'(1);

	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= `SPAWN_SEED;
		else if (spawn)
			lfsr <= lfsr[0] ? ((lfsr >> 1) ^ `SPAWN_TAPS) : (lfsr >> 1);
	end

	//////////////////////////////////////////////////
	// First empty cell at or after start, wrapping.
	//////////////////////////////////////////////////
	always_comb begin : scan
		logic [IDX_W-1:0] idx;

		found = 1'b0;
		pos   = '0;
		for (int k = 0; k < CELLS; k++) begin
			idx = start + IDX_W'(k);
			if (!found && grid[idx*W +: W] == '0) begin
				found = 1'b1;
				pos   = idx;
			end
		end

		grid_spawned = grid;
		if (found)
			grid_spawned[pos*W +: W] = new_val;
	end

	assign has_empty = found;

	a_spawn_has_room: assert property (@(posedge clk) disable iff (reset)
		spawn |-> has_empty);

endmodule

/* rtl/game_fsm.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module game_fsm (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                mv_valid,
	input  game_pkg::dir_t                      mv_dir,
	output logic                                mv_ready,
	output logic [`GRID_N*`GRID_N*`TILE_W-1:0]  grid,
	output logic                                win,
	output logic                                defeat,
	output logic                                active
);
	import game_pkg::*;

	localparam int N      = `GRID_N;
	localparam int W      = `TILE_W;
	localparam int LINE_W = N * W;
	localparam int GRID_W = N * N * W;

	fsm_state_t        state;
	dir_t              dir_q;
	dir_t              cur_dir;
	logic [1:0]        chk_cnt;
	logic [LINE_W-1:0] line_in  [N];
	logic [LINE_W-1:0] line_out [N];
	logic [GRID_W-1:0] grid_slid;
	logic [GRID_W-1:0] grid_spawned;
	logic              has_empty;
	logic              spawn;
	logic              moved;
	logic              has_win;
	logic              cell_over;

	// Cell index of position p in line l, head first.
	function automatic int cell_pos(input dir_t d, input int l, input int p);
		case (d)
			dir_left:  return l * N + p;
			dir_right: return l * N + (N - 1 - p);
			dir_up:    return p * N + l;
			default:   return (N - 1 - p) * N + l;
		endcase
	endfunction

	// The check sweep walks all directions.
	assign cur_dir = (state == st_check) ? dir_t'(chk_cnt) : dir_q;

	//////////////////////////////////////////////////
	// Gather, slide, scatter.
	//////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < N; l++)
			for (int p = 0; p < N; p++)
				line_in[l][p*W +: W] = grid[cell_pos(cur_dir, l, p)*W +: W];
	end

	for (genvar g = 0; g < N; g++) begin : g_line
		tile_slide i_tile_slide (
			.line_in  (line_in[g]),
			.line_out (line_out[g])
		);
	end

	always_comb begin
		grid_slid = '0;
		for (int l = 0; l < N; l++)
			for (int p = 0; p < N; p++)
				grid_slid[cell_pos(cur_dir, l, p)*W +: W] = line_out[l][p*W +: W];
	end

	assign moved = (grid_slid != grid);

	tile_spawner i_tile_spawner (
		.clk          (clk),
		.reset        (reset),
		.spawn        (spawn),
		.grid         (grid),
		.grid_spawned (grid_spawned),
		.has_empty    (has_empty)
	);

	always_comb begin
		has_win   = 1'b0;
		cell_over = 1'b0;
		for (int i = 0; i < N * N; i++) begin
			if (grid[i*W +: W] == W'(`WIN_EXP))
				has_win = 1'b1;
			if (grid[i*W +: W] > W'(`WIN_EXP))
				cell_over = 1'b1;
		end
	end

	assign spawn    = (state == st_start) || (state == st_spawn);
	assign mv_ready = (state == st_idle) || (state == st_play);
	assign active   = !mv_ready;
	assign win      = (state == st_win);
	assign defeat   = (state == st_defeat);

	//////////////////////////////////////////////////
	// Sequencing.
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_idle;
			grid    <= '0;
			chk_cnt <= 2'd0;
		end else begin
			case (state)
				st_idle:
					if (mv_valid)
						state <= st_start;
				// chk_cnt doubles as the count of opening tiles.
				st_start: begin
					grid <= grid_spawned;
					if (chk_cnt == 2'd1) begin
						chk_cnt <= 2'd0;
						state   <= st_play;
					end else begin
						chk_cnt <= chk_cnt + 2'd1;
					end
				end
				st_play:
					if (mv_valid)
						state <= st_slide;
				st_slide: begin
					grid  <= grid_slid;
					state <= moved ? st_spawn : st_play;
				end
				st_spawn: begin
					grid  <= grid_spawned;
					state <= st_check;
				end
				st_check: begin
					if (has_win) begin
						state <= st_win;
					end else if (has_empty || moved) begin
						chk_cnt <= 2'd0;
						state   <= st_play;
					end else if (chk_cnt == 2'd3) begin
						chk_cnt <= 2'd0;
						state   <= st_defeat;
					end else begin
						chk_cnt <= chk_cnt + 2'd1;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_play && mv_valid)
			dir_q <= mv_dir;
	end

	// Win is terminal, so no merge goes past it.
	a_cell_max: assert property (@(posedge clk) disable iff (reset) !cell_over);

endmodule

/* rtl/game_top.sv */
`timescale 1ns/1ps

module game_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        btn_left,
	input  logic        btn_right,
	input  logic        btn_up,
	input  logic        btn_down,
	output logic [63:0] grid,
	output logic        win,
	output logic        defeat,
	output logic        busy
);
	import game_pkg::*;

	logic req_valid, req_ready;
	logic mv_valid, mv_ready;
	dir_t req_dir, mv_dir;
	logic fifo_empty;
	logic active;

	button_edge i_button_edge (
		.clk       (clk),
		.reset     (reset),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_up    (btn_up),
		.btn_down  (btn_down),
		.req_valid (req_valid),
		.req_dir   (req_dir),
		.req_ready (req_ready)
	);

	move_fifo i_move_fifo (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_dir   (req_dir),
		.req_ready (req_ready),
		.mv_valid  (mv_valid),
		.mv_dir    (mv_dir),
		.mv_ready  (mv_ready),
		.empty     (fifo_empty)
	);

	game_fsm i_game_fsm (
		.clk      (clk),
		.reset    (reset),
		.mv_valid (mv_valid),
		.mv_dir   (mv_dir),
		.mv_ready (mv_ready),
		.grid     (grid),
		.win      (win),
		.defeat   (defeat),
		.active   (active)
	);

	// Queued moves count as pending work.
	assign busy = active | ~fifo_empty;

endmodule

/* tests/game_checker.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module game_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        btn_left,
	input  logic        btn_right,
	input  logic        btn_up,
	input  logic        btn_down,
	input  logic [63:0] grid,
	input  logic        win,
	input  logic        defeat,
	input  logic        busy,
	output int          error_count,
	output int          compare_count
);
	import game_pkg::*;

	logic [63:0] m_grid;
	logic [15:0] m_lfsr;
	logic        m_started;
	logic        m_win;
	logic        m_defeat;
	dir_t        rel_dir [$];
	int          rel_time [$];
	logic [3:0]  btn_q;
	logic        kept_q, busy_q, win_q, defeat_q;
	int          sample;

	// Flat cell index of position p along line l, counted from the head.
	function automatic int line_cell(input dir_t d, input int l, input int p);
		case (d)
			dir_left:  return 4 * l + p;
			dir_right: return 4 * l + 3 - p;
			dir_up:    return 4 * p + l;
			default:   return 4 * (3 - p) + l;
		endcase
	endfunction

	function automatic logic [63:0] slid(input logic [63:0] g, input dir_t d);
		logic [63:0] r;
		logic [3:0]  q [$];
		int          o;

		r = '0;
		for (int l = 0; l < 4; l++) begin
			q.delete();
			for (int p = 0; p < 4; p++)
				if (g[4 * line_cell(d, l, p) +: 4] != 4'd0)
					q.push_back(g[4 * line_cell(d, l, p) +: 4]);
			o = 0;
			while (q.size() > 0) begin
				if (q.size() > 1 && q[0] == q[1]) begin
					r[4 * line_cell(d, l, o) +: 4] = q[0] + 4'd1;
					void'(q.pop_front());
				end else begin
					r[4 * line_cell(d, l, o) +: 4] = q[0];
				end
				void'(q.pop_front());
				o++;
			end
		end
		return r;
	endfunction

	function automatic logic [63:0] spawned(input logic [63:0] g, input logic [15:0] lfsr);
		int idx;

		for (int k = 0; k < 16; k++) begin
			idx = (lfsr[3:0] + k) % 16;
			if (g[4 * idx +: 4] == 4'd0) begin
				g[4 * idx +: 4] = (lfsr[7:5] == 3'd0) ? 4'd2 : 4'd1;
				return g;
			end
		end
		return g;
	endfunction

	function automatic logic reached_win(input logic [63:0] g);
		for (int i = 0; i < 16; i++)
			if (g[4 * i +: 4] == `WIN_EXP)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic spawn_tile();
		m_grid = spawned(m_grid, m_lfsr);
		m_lfsr = m_lfsr[0] ? ((m_lfsr >> 1) ^ `SPAWN_TAPS) : (m_lfsr >> 1);
	endtask

	task automatic apply_move(input dir_t d);
		logic [63:0] g;
		logic        stuck;

		if (m_win || m_defeat)
			return;
		// The opening press only places two tiles.
		if (!m_started) begin
			m_started = 1'b1;
			spawn_tile();
			spawn_tile();
			return;
		end
		g = slid(m_grid, d);
		if (g == m_grid)
			return;
		m_grid = g;
		spawn_tile();
		// A grid with a hole always has some move, so stuck means full too.
		stuck = 1'b1;
		for (int i = 0; i < 4; i++)
			if (slid(m_grid, dir_t'(i)) != m_grid)
				stuck = 1'b0;
		m_win = reached_win(m_grid);
		m_defeat = !m_win && stuck;
	endtask

	function automatic dir_t pick_dir(input logic [3:0] rel);
		if (rel[1])
			return dir_right;
		if (rel[0])
			return dir_left;
		if (rel[2])
			return dir_up;
		return dir_down;
	endfunction

	task automatic check_value(input string name, input logic [63:0] dut, input logic [63:0] exp);
		compare_count++;
		if (dut !== exp) begin
			error_count++;
			$display("Mismatch %s: dut %0h, model %0h at %0t", name, dut, exp, $time);
		end
	endtask

	//////////////////////////////////////////////////
	// Mid-cycle sampling of buttons and outputs.
	//////////////////////////////////////////////////
	always @(negedge clk) begin : watch
		logic [3:0] now;
		logic [3:0] rel;
		logic       keep;
		logic       fall;
		logic       rise;

		now = {btn_down, btn_up, btn_right, btn_left};
		if (reset) begin
			m_grid = '0;
			m_lfsr = `SPAWN_SEED;
			m_started = 1'b0;
			m_win = 1'b0;
			m_defeat = 1'b0;
			rel_dir.delete();
			rel_time.delete();
			btn_q = 4'b0000;
			kept_q = 1'b0;
			busy_q = 1'b0;
			win_q = 1'b0;
			defeat_q = 1'b0;
			sample = 0;
			error_count = 0;
			compare_count = 0;
		end else begin
			sample++;
			if (!m_started && rel_dir.size() == 0) begin
				check_value("grid", grid, 64'd0);
				check_value("busy", busy, 64'd0);
				check_value("win", win, 64'd0);
				check_value("defeat", defeat, 64'd0);
			end

			// Busy low only covers releases at least two samples old.
			fall = busy_q && !busy;
			rise = (win && !win_q) || (defeat && !defeat_q);
			if (fall || rise || m_win || m_defeat) begin
				while (rel_time.size() > 0 && rel_time[0] <= sample - 2) begin
					apply_move(rel_dir.pop_front());
					void'(rel_time.pop_front());
				end
				check_value("grid", grid, m_grid);
				check_value("win", win, m_win);
				check_value("defeat", defeat, m_defeat);
			end

			// One release held at a time.
			rel = btn_q & ~now;
			keep = (rel != 4'b0000) && !kept_q;
			if (keep) begin
				rel_dir.push_back(pick_dir(rel));
				rel_time.push_back(sample);
			end
			kept_q = keep;
			btn_q = now;
			busy_q = busy;
			win_q = win;
			defeat_q = defeat;
		end
	end

endmodule

/* tests/game_tb.sv */
`timescale 1ns/1ps

module game_tb;

	localparam int SINGLE_N = 40;
	localparam int BURST_N  = 12;
	localparam int SIMUL_N  = 8;
	localparam int GAME_N   = 3000;
	localparam int AFTER_N  = 6;
	localparam int PRESS_N  = 1 + SINGLE_N + 4 * BURST_N + SIMUL_N + GAME_N + AFTER_N;
	localparam int WATCHDOG_CYCLES = PRESS_N * 40 + 200;

	logic        clk;
	logic        reset;
	logic        btn_left, btn_right, btn_up, btn_down;
	logic [63:0] grid;
	logic        win, defeat, busy;
	logic [31:0] rng;
	int          error_count;
	int          compare_count;
	int          wait_errors;

	game_top i_game_top (
		.clk       (clk),
		.reset     (reset),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_up    (btn_up),
		.btn_down  (btn_down),
		.grid      (grid),
		.win       (win),
		.defeat    (defeat),
		.busy      (busy)
	);

	game_checker i_game_checker (
		.clk           (clk),
		.reset         (reset),
		.btn_left      (btn_left),
		.btn_right     (btn_right),
		.btn_up        (btn_up),
		.btn_down      (btn_down),
		.grid          (grid),
		.win           (win),
		.defeat        (defeat),
		.busy          (busy),
		.error_count   (error_count),
		.compare_count (compare_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Two cycles high, then low. Bit order follows dir_t.
	task automatic release_buttons(input logic [3:0] mask);
		@(posedge clk);
		#1;
		{btn_down, btn_up, btn_right, btn_left} = mask;
		repeat (2) @(posedge clk);
		#1;
		{btn_down, btn_up, btn_right, btn_left} = 4'b0000;
	endtask

	task automatic press_random();
		rng = xorshift32(rng);
		release_buttons(4'b0001 << rng[1:0]);
	endtask

	// The release reaches the FIFO two cycles after the button drops.
	task automatic wait_settled();
		int n;

		n = 0;
		repeat (3) @(posedge clk);
		#1;
		while (busy && !win && !defeat && n < 60) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (busy && !win && !defeat) begin
			wait_errors++;
			$display("Timed out waiting for busy to fall at %0t", $time);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus.
	//////////////////////////////////////////////////
	initial begin : main
		int         burst;
		logic [1:0] a;
		logic [1:0] b;

		reset = 1'b1;
		{btn_down, btn_up, btn_right, btn_left} = 4'b0000;
		rng = 32'h61ed1a0d;
		wait_errors = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		// Idle grid is watched here with nothing pressed.
		repeat (5) @(posedge clk);

		press_random();
		wait_settled();

		for (int i = 0; i < SINGLE_N; i++) begin
			press_random();
			wait_settled();
		end

		for (int i = 0; i < BURST_N; i++) begin
			rng = xorshift32(rng);
			burst = 2 + int'(rng % 3);
			repeat (burst)
				press_random();
			wait_settled();
		end

		// At least two buttons in each release.
		for (int i = 0; i < SIMUL_N; i++) begin
			rng = xorshift32(rng);
			a = rng[1:0];
			b = a + 2'd1 + {1'b0, rng[2]};
			release_buttons((4'b0001 << a) | (4'b0001 << b) | rng[7:4]);
			wait_settled();
		end

		for (int i = 0; i < GAME_N && !win && !defeat; i++) begin
			press_random();
			wait_settled();
		end
		if (!win && !defeat) begin
			wait_errors++;
			$display("Game reached neither win nor defeat after %0d random moves", GAME_N);
		end

		repeat (AFTER_N) begin
			press_random();
			wait_settled();
		end
		repeat (10) @(posedge clk);

		$display("Done: %0d checks, %0d mismatches, %0d other errors",
			compare_count, error_count, wait_errors);
		if (error_count + wait_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Done: %0d checks, %0d mismatches, %0d other errors",
			compare_count, error_count, wait_errors + 1);
		$display("Test failures found");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
rtl/game_pkg.sv
rtl/button_edge.sv
rtl/move_fifo.sv
rtl/tile_slide.sv
rtl/tile_spawner.sv
rtl/game_fsm.sv
rtl/game_top.sv
tests/game_checker.sv
tests/game_tb.sv

/* Bender.yml */
package:
  name: game_2048

export_include_dirs:
  - include

sources:
  - rtl/game_pkg.sv
  - rtl/button_edge.sv
  - rtl/move_fifo.sv
  - rtl/tile_slide.sv
  - rtl/tile_spawner.sv
  - rtl/game_fsm.sv
  - rtl/game_top.sv
  - target: test
    files:
      - tests/game_checker.sv
      - tests/game_tb.sv
